/* src/exu_defines.svh */
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// datapath width of the core
`define EXU_XLEN 64

// restoring divider steps, one quotient bit per cycle
`define EXU_DIV_ITERS 64
`define EXU_DIV_ITERS_W 32

// wide enough to hold EXU_DIV_ITERS
`define EXU_CNT_W 7

`endif

/* src/exu_pkg.sv */
package exu_pkg;

  // operation class, picks the unit that executes
  typedef enum logic [1:0] {
    cls_alu = 2'd0,
    cls_bjp = 2'd1,
    cls_div = 2'd2
  } exu_class_e;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_srl  = 4'd3,
    alu_sra  = 4'd4,
    alu_slt  = 4'd5,
    alu_sltu = 4'd6,
    alu_xor  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9,
    alu_lui  = 4'd10
  } alu_op_e;

  typedef enum logic [2:0] {
    bjp_jal  = 3'd0,
    bjp_jalr = 3'd1,
    bjp_beq  = 3'd2,
    bjp_bne  = 3'd3,
    bjp_blt  = 3'd4,
    bjp_bge  = 3'd5,
    bjp_bltu = 3'd6,
    bjp_bgeu = 3'd7
  } bjp_op_e;

  typedef enum logic [1:0] {
    div_div  = 2'd0,
    div_divu = 2'd1,
    div_rem  = 2'd2,
    div_remu = 2'd3
  } div_op_e;

  // st_out means the output register holds a result
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_div  = 2'd1,
    st_out  = 2'd2
  } ctrl_state_e;

endpackage

/* src/exu_alu.sv */
`timescale 1ns/1ns
`include "exu_defines.svh"

module exu_alu
  import exu_pkg::*;
(
  input  exu_class_e           class_i,
  input  logic [3:0]           op_i,
  input  logic                 word_i,
  input  logic [`EXU_XLEN-1:0] op1_i,
  input  logic [`EXU_XLEN-1:0] op2_i,
  input  logic [`EXU_XLEN-1:0] pc_i,
  input  logic [`EXU_XLEN-1:0] imm_i,
  output logic [`EXU_XLEN-1:0] res_o,
  output logic                 jump_o,
  output logic [`EXU_XLEN-1:0] jump_addr_o
);

  alu_op_e              alu_op;
  bjp_op_e              bjp_op;
  logic                 is_alu;
  logic                 is_bjp;
  logic                 is_link;
  logic                 sub_need;
  logic [`EXU_XLEN-1:0] adder_in2;
  logic                 adder_cout;
  logic [`EXU_XLEN-1:0] adder_res;
  logic                 lt_s;
  logic                 lt_u;
  logic                 eq;
  logic [`EXU_XLEN-1:0] sll_res;
  logic [`EXU_XLEN-1:0] srl_res;
  logic [`EXU_XLEN-1:0] sra_res;
  logic [31:0]          sllw_res;
  logic [31:0]          srlw_res;
  logic [31:0]          sraw_res;
  logic [`EXU_XLEN-1:0] link;
  logic [`EXU_XLEN-1:0] jmp_base;
  logic [`EXU_XLEN-1:0] jmp_sum;
  logic                 cond;

  assign alu_op  = alu_op_e'(op_i);
  assign bjp_op  = bjp_op_e'(op_i[2:0]);
  assign is_alu  = class_i == cls_alu;
  assign is_bjp  = class_i == cls_bjp;
  assign is_link = is_bjp && (bjp_op == bjp_jal || bjp_op == bjp_jalr);

  // one adder for add/sub, set-less-than and branch compares
  assign sub_need = (is_alu && (alu_op == alu_sub || alu_op == alu_slt || alu_op == alu_sltu))
                  || (is_bjp && !is_link);
  assign adder_in2 = sub_need ? ~op2_i : op2_i;
  assign {adder_cout, adder_res} = {1'b0, op1_i} + {1'b0, adder_in2}
                                 + {{`EXU_XLEN{1'b0}}, sub_need};

  assign lt_s = (op1_i[`EXU_XLEN-1] & ~op2_i[`EXU_XLEN-1])
              | (~(op1_i[`EXU_XLEN-1] ^ op2_i[`EXU_XLEN-1]) & adder_res[`EXU_XLEN-1]);
  // no carry out of a - b means a < b unsigned
  assign lt_u = ~adder_cout;
  assign eq   = adder_res == '0;

  assign sll_res = op1_i << op2_i[5:0];
  assign srl_res = op1_i >> op2_i[5:0];
  assign sra_res = $signed(op1_i) >>> op2_i[5:0];

  // word shifts only look at 5 bits of shamt
  assign sllw_res = op1_i[31:0] << op2_i[4:0];
  assign srlw_res = op1_i[31:0] >> op2_i[4:0];
  assign sraw_res = $signed(op1_i[31:0]) >>> op2_i[4:0];

  always_comb begin
    res_o = '0;
    if (is_alu) begin
      case (alu_op)
        alu_add, alu_sub: res_o = word_i ? {{32{adder_res[31]}}, adder_res[31:0]} : adder_res;
        alu_sll:  res_o = word_i ? {{32{sllw_res[31]}}, sllw_res} : sll_res;
        alu_srl:  res_o = word_i ? {{32{srlw_res[31]}}, srlw_res} : srl_res;
        alu_sra:  res_o = word_i ? {{32{sraw_res[31]}}, sraw_res} : sra_res;
        alu_slt:  res_o = {{(`EXU_XLEN-1){1'b0}}, lt_s};
        alu_sltu: res_o = {{(`EXU_XLEN-1){1'b0}}, lt_u};
        alu_xor:  res_o = op1_i ^ op2_i;
        alu_or:   res_o = op1_i | op2_i;
        alu_and:  res_o = op1_i & op2_i;
        // decoder hands over the shifted upper immediate as op2
        alu_lui:  res_o = op2_i;
        default:  res_o = '0;
      endcase
    end else if (is_link) begin
      res_o = link;
    end
  end

  always_comb begin
    case (bjp_op)
      bjp_jal, bjp_jalr: cond = 1'b1;
      bjp_beq:  cond = eq;
      bjp_bne:  cond = !eq;
      bjp_blt:  cond = lt_s;
      bjp_bge:  cond = !lt_s;
      bjp_bltu: cond = lt_u;
      bjp_bgeu: cond = !lt_u;
      default:  cond = 1'b0;
    endcase
  end

  // return address for jal/jalr
  assign link = pc_i + `EXU_XLEN'd4;

  // jalr is register based, the rest pc relative
  assign jmp_base = (bjp_op == bjp_jalr) ? op1_i : pc_i;
  assign jmp_sum  = jmp_base + imm_i;

  assign jump_o      = is_bjp & cond;
  assign jump_addr_o = !is_bjp ? '0
                     : (bjp_op == bjp_jalr) ? {jmp_sum[`EXU_XLEN-1:1], 1'b0}
                     : jmp_sum;

endmodule

/* src/exu_div.sv */
`timescale 1ns/1ns
`include "exu_defines.svh"

module exu_div
  import exu_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 start_i,
  input  logic [1:0]           op_i,
  input  logic                 word_i,
  input  logic [`EXU_XLEN-1:0] op1_i,
  input  logic [`EXU_XLEN-1:0] op2_i,
  input  logic                 last_i,
  output logic                 done_o,
  output logic [`EXU_XLEN-1:0] res_o
);

  div_op_e              div_op;
  logic                 is_signed;
  logic                 is_rem;
  logic                 a_sign;
  logic                 b_sign;
  logic [`EXU_XLEN-1:0] a_neg;
  logic [`EXU_XLEN-1:0] b_neg;
  logic [`EXU_XLEN-1:0] a_mag;
  logic [`EXU_XLEN-1:0] b_mag;
  logic                 b_zero;
  logic                 ovf;
  logic                 run_q;
  logic [`EXU_XLEN-1:0] quo_q;
  logic [`EXU_XLEN-1:0] rem_q;
  logic [`EXU_XLEN-1:0] dvs_q;
  logic [`EXU_XLEN:0]   shifted;
  logic [`EXU_XLEN+1:0] diff;
  logic [`EXU_XLEN-1:0] quo_fix;
  logic [`EXU_XLEN-1:0] rem_fix;
  logic [`EXU_XLEN-1:0] quo_res;
  logic [`EXU_XLEN-1:0] rem_res;
  logic [`EXU_XLEN-1:0] res_full;

  assign div_op    = div_op_e'(op_i);
  assign is_signed = div_op == div_div || div_op == div_rem;
  assign is_rem    = div_op == div_rem || div_op == div_remu;

  // operand fields stay put until the result is taken
  assign a_sign = word_i ? op1_i[31] : op1_i[`EXU_XLEN-1];
  assign b_sign = word_i ? op2_i[31] : op2_i[`EXU_XLEN-1];
  assign a_neg  = -op1_i;
  assign b_neg  = -op2_i;
  assign a_mag  = (is_signed && a_sign) ? (word_i ? {32'b0, a_neg[31:0]} : a_neg)
                                        : (word_i ? {32'b0, op1_i[31:0]} : op1_i);
  assign b_mag  = (is_signed && b_sign) ? (word_i ? {32'b0, b_neg[31:0]} : b_neg)
                                        : (word_i ? {32'b0, op2_i[31:0]} : op2_i);

  assign b_zero = word_i ? (op2_i[31:0] == '0) : (op2_i == '0);
  // most negative dividend over minus one
  assign ovf = is_signed && (word_i ? (op1_i[31:0] == 32'h8000_0000 && &op2_i[31:0])
                                    : (op1_i == {1'b1, {(`EXU_XLEN-1){1'b0}}} && &op2_i));

  // trial subtract of the divisor from the shifted partial remainder
  assign shifted = {rem_q, quo_q[`EXU_XLEN-1]};
  assign diff    = {1'b0, shifted} - {2'b0, dvs_q};

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      run_q  <= 1'b0;
      done_o <= 1'b0;
    end else begin
      done_o <= run_q & last_i;
      if (start_i) begin
        run_q <= 1'b1;
      end else if (last_i) begin
        run_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      // word dividend sits in the top half so 32 steps consume it
      quo_q <= word_i ? {a_mag[31:0], 32'b0} : a_mag;
      rem_q <= '0;
      dvs_q <= b_mag;
    end else if (run_q) begin
      quo_q <= {quo_q[`EXU_XLEN-2:0], ~diff[`EXU_XLEN+1]};
      rem_q <= diff[`EXU_XLEN+1] ? shifted[`EXU_XLEN-1:0] : diff[`EXU_XLEN-1:0];
    end
  end

  // quotient negative on differing signs, remainder follows the dividend
  assign quo_fix = (is_signed && (a_sign ^ b_sign)) ? -quo_q : quo_q;
  assign rem_fix = (is_signed && a_sign) ? -rem_q : rem_q;

  always_comb begin
    if (b_zero) begin
      quo_res = '1;
      rem_res = op1_i;
    end else if (ovf) begin
      quo_res = op1_i;
      rem_res = '0;
    end else begin
      quo_res = quo_fix;
      rem_res = rem_fix;
    end
  end

  assign res_full = is_rem ? rem_res : quo_res;
  assign res_o    = word_i ? {{32{res_full[31]}}, res_full[31:0]} : res_full;

endmodule

/* src/exu_div_cnt.sv */
`timescale 1ns/1ns
`include "exu_defines.svh"

module exu_div_cnt (
  input  logic clk,
  input  logic arst_n_i,
  input  logic start_i,
  input  logic word_i,
  output logic busy_o,
  output logic last_o
);

  localparam logic [`EXU_CNT_W-1:0] iters_full = `EXU_DIV_ITERS;
  localparam logic [`EXU_CNT_W-1:0] iters_word = `EXU_DIV_ITERS_W;
  localparam logic [`EXU_CNT_W-1:0] cnt_one    = 1;

  logic [`EXU_CNT_W-1:0] cnt_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= word_i ? iters_word : iters_full;
    end else if (busy_o) begin
      cnt_q <= cnt_q - cnt_one;
    end
  end

  assign busy_o = cnt_q != '0;
  // final divider step happens at the next edge
  assign last_o = cnt_q == cnt_one;

endmodule

/* src/exu_ctrl.sv */
`timescale 1ns/1ns
`include "exu_defines.svh"

module exu_ctrl
  import exu_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  exu_class_e           class_i,
  input  logic [3:0]           op_i,
  input  logic                 word_i,
  input  logic [`EXU_XLEN-1:0] op1_i,
  input  logic [`EXU_XLEN-1:0] op2_i,
  input  logic [`EXU_XLEN-1:0] pc_i,
  input  logic [`EXU_XLEN-1:0] imm_i,
  input  logic [4:0]           rd_idx_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [`EXU_XLEN-1:0] res_o,
  output logic [4:0]           rd_idx_o,
  output logic                 jump_o,
  output logic [`EXU_XLEN-1:0] jump_addr_o,
  input  logic [`EXU_XLEN-1:0] alu_res_i,
  input  logic                 jump_i,
  input  logic [`EXU_XLEN-1:0] jump_addr_i,
  output logic                 div_start_o,
  input  logic                 div_done_i,
  input  logic [`EXU_XLEN-1:0] div_res_i,
  output exu_class_e           class_q_o,
  output logic [3:0]           op_q_o,
  output logic                 word_q_o,
  output logic [`EXU_XLEN-1:0] op1_q_o,
  output logic [`EXU_XLEN-1:0] op2_q_o,
  output logic [`EXU_XLEN-1:0] pc_q_o,
  output logic [`EXU_XLEN-1:0] imm_q_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        live_q;
  logic        alu_q;
  logic        pend_q;
  logic        pend_d;
  logic        start_d;
  logic        free;
  logic        accept;
  logic        acc_div;
  logic        load_alu;
  logic        load_div;
  logic [4:0]  rd_q;

  // output register empty, or emptied at this edge
  assign free     = (state_q == st_idle) || (state_q == st_out && out_ready_i);
  // live_q keeps ready low until the first edge out of reset
  assign in_ready_o  = live_q & free & ~pend_q;
  assign accept      = in_valid_i & in_ready_o;
  assign acc_div     = accept && class_i == cls_div;
  // alu_q marks captured fields whose ALU result is not registered yet
  assign load_alu    = free & alu_q;
  assign load_div    = (state_q == st_div) & div_done_i;
  assign out_valid_o = state_q == st_out;

  always_comb begin
    state_d = state_q;
    pend_d  = pend_q;
    start_d = 1'b0;
    if (free) begin
      if (alu_q) begin
        // a divide arriving now waits until this result drains
        state_d = st_out;
        pend_d  = acc_div;
      end else if (pend_q || acc_div) begin
        state_d = st_div;
        pend_d  = 1'b0;
        start_d = 1'b1;
      end else begin
        state_d = st_idle;
      end
    end else if (load_div) begin
      state_d = st_out;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= st_idle;
      live_q      <= 1'b0;
      alu_q       <= 1'b0;
      pend_q      <= 1'b0;
      div_start_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      live_q      <= 1'b1;
      pend_q      <= pend_d;
      div_start_o <= start_d;
      if (accept) begin
        alu_q <= class_i != cls_div;
      end else if (load_alu) begin
        alu_q <= 1'b0;
      end
    end
  end

  // operation fields, held while the op is being executed
  always_ff @(posedge clk) begin
    if (accept) begin
      class_q_o <= class_i;
      op_q_o    <= op_i;
      word_q_o  <= word_i;
      op1_q_o   <= op1_i;
      op2_q_o   <= op2_i;
      pc_q_o    <= pc_i;
      imm_q_o   <= imm_i;
      rd_q      <= rd_idx_i;
    end
  end

  always_ff @(posedge clk) begin
    if (load_alu) begin
      res_o       <= alu_res_i;
      jump_o      <= jump_i;
      jump_addr_o <= jump_addr_i;
      rd_idx_o    <= rd_q;
    end else if (load_div) begin
      res_o       <= div_res_i;
      jump_o      <= 1'b0;
      jump_addr_o <= '0;
      rd_idx_o    <= rd_q;
    end
  end

endmodule

/* src/exu_top.sv */
`timescale 1ns/1ns
`include "exu_defines.svh"

module exu_top
  import exu_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  exu_class_e           class_i,
  input  logic [3:0]           op_i,
  input  logic                 word_i,
  input  logic [`EXU_XLEN-1:0] op1_i,
  input  logic [`EXU_XLEN-1:0] op2_i,
  input  logic [`EXU_XLEN-1:0] pc_i,
  input  logic [`EXU_XLEN-1:0] imm_i,
  input  logic [4:0]           rd_idx_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [`EXU_XLEN-1:0] res_o,
  output logic [4:0]           rd_idx_o,
  output logic                 jump_o,
  output logic [`EXU_XLEN-1:0] jump_addr_o
);

  exu_class_e           class_q;
  logic [3:0]           op_q;
  logic                 word_q;
  logic [`EXU_XLEN-1:0] op1_q;
  logic [`EXU_XLEN-1:0] op2_q;
  logic [`EXU_XLEN-1:0] pc_q;
  logic [`EXU_XLEN-1:0] imm_q;
  logic [`EXU_XLEN-1:0] alu_res;
  logic                 alu_jump;
  logic [`EXU_XLEN-1:0] alu_jump_addr;
  logic                 div_start;
  logic                 div_done;
  logic [`EXU_XLEN-1:0] div_res;
  logic                 div_last;
  // divider activity, watched by the checker
  logic                 div_busy;

  exu_ctrl u_ctrl (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .class_i     (class_i),
    .op_i        (op_i),
    .word_i      (word_i),
    .op1_i       (op1_i),
    .op2_i       (op2_i),
    .pc_i        (pc_i),
    .imm_i       (imm_i),
    .rd_idx_i    (rd_idx_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .res_o       (res_o),
    .rd_idx_o    (rd_idx_o),
    .jump_o      (jump_o),
    .jump_addr_o (jump_addr_o),
    .alu_res_i   (alu_res),
    .jump_i      (alu_jump),
    .jump_addr_i (alu_jump_addr),
    .div_start_o (div_start),
    .div_done_i  (div_done),
    .div_res_i   (div_res),
    .class_q_o   (class_q),
    .op_q_o      (op_q),
    .word_q_o    (word_q),
    .op1_q_o     (op1_q),
    .op2_q_o     (op2_q),
    .pc_q_o      (pc_q),
    .imm_q_o     (imm_q)
  );

  exu_alu u_alu (
    .class_i     (class_q),
    .op_i        (op_q),
    .word_i      (word_q),
    .op1_i       (op1_q),
    .op2_i       (op2_q),
    .pc_i        (pc_q),
    .imm_i       (imm_q),
    .res_o       (alu_res),
    .jump_o      (alu_jump),
    .jump_addr_o (alu_jump_addr)
  );

  exu_div u_div (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .start_i  (div_start),
    .op_i     (op_q[1:0]),
    .word_i   (word_q),
    .op1_i    (op1_q),
    .op2_i    (op2_q),
    .last_i   (div_last),
    .done_o   (div_done),
    .res_o    (div_res)
  );

  exu_div_cnt u_div_cnt (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .start_i  (div_start),
    .word_i   (word_q),
    .busy_o   (div_busy),
    .last_o   (div_last)
  );

endmodule

/* dv/exu_checker.sv */
`timescale 1ns/1ns
`include "exu_defines.svh"

module exu_checker (
  input logic                 clk,
  input logic                 arst_n_i,
  input logic                 in_ready_i,
  input logic                 out_valid_i,
  input logic                 out_ready_i,
  input logic [`EXU_XLEN-1:0] res_i,
  input logic [4:0]           rd_idx_i,
  input logic                 jump_i,
  input logic [`EXU_XLEN-1:0] jump_addr_i,
  input logic                 div_busy_i
);

  // a stalled result holds until taken
  stall_stable_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(res_i) && $stable(rd_idx_i)
      && $stable(jump_i) && $stable(jump_addr_i))
    else $error("outputs changed while the result was stalled");

  div_no_accept_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    div_busy_i |-> !in_ready_i)
    else $error("in_ready_o high while the divider is running");

  reset_quiet_a: assert property (@(posedge clk) !arst_n_i |-> !out_valid_i)
    else $error("out_valid_o high during reset");

endmodule

bind exu_top exu_checker u_checker (
  .clk         (clk),
  .arst_n_i    (arst_n_i),
  .in_ready_i  (in_ready_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .res_i       (res_o),
  .rd_idx_i    (rd_idx_o),
  .jump_i      (jump_o),
  .jump_addr_i (jump_addr_o),
  .div_busy_i  (div_busy)
);

/* dv/exu_tb.sv */
`timescale 1ns/1ns
`include "exu_defines.svh"

module exu_tb
  import exu_pkg::*;
();

  localparam int max_vecs     = 64;
  localparam int wait_limit   = 200;
  localparam int reset_cycles = 10;

  logic                 clk;
  logic                 arst_n_i;
  logic                 in_valid_i;
  logic                 in_ready_o;
  exu_class_e           class_i;
  logic [3:0]           op_i;
  logic                 word_i;
  logic [`EXU_XLEN-1:0] op1_i;
  logic [`EXU_XLEN-1:0] op2_i;
  logic [`EXU_XLEN-1:0] pc_i;
  logic [`EXU_XLEN-1:0] imm_i;
  logic [4:0]           rd_idx_i;
  logic                 out_valid_o;
  logic                 out_ready_i;
  logic [`EXU_XLEN-1:0] res_o;
  logic [4:0]           rd_idx_o;
  logic                 jump_o;
  logic [`EXU_XLEN-1:0] jump_addr_o;

  // operation table loaded from the vector file
  string                vec_name  [max_vecs];
  logic [1:0]           vec_class [max_vecs];
  logic [3:0]           vec_op    [max_vecs];
  logic                 vec_word  [max_vecs];
  logic [`EXU_XLEN-1:0] vec_op1   [max_vecs];
  logic [`EXU_XLEN-1:0] vec_op2   [max_vecs];
  logic [`EXU_XLEN-1:0] vec_pc    [max_vecs];
  logic [`EXU_XLEN-1:0] vec_imm   [max_vecs];
  logic [4:0]           vec_rd    [max_vecs];
  logic [`EXU_XLEN-1:0] vec_res   [max_vecs];
  logic                 vec_jump  [max_vecs];
  logic [`EXU_XLEN-1:0] vec_jaddr [max_vecs];
  int                   num_vecs;
  // indices of accepted operations, oldest first
  int                   pending [$];

  exu_top u_exu_top (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .class_i     (class_i),
    .op_i        (op_i),
    .word_i      (word_i),
    .op1_i       (op1_i),
    .op2_i       (op2_i),
    .pc_i        (pc_i),
    .imm_i       (imm_i),
    .rd_idx_i    (rd_idx_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .res_o       (res_o),
    .rd_idx_o    (rd_idx_o),
    .jump_o      (jump_o),
    .jump_addr_o (jump_addr_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic read_vectors();
    int          fd;
    int          cnt;
    string       line;
    string       name;
    logic [63:0] f_cls, f_op, f_word, f_a, f_b, f_pc, f_imm, f_rd, f_res, f_jmp, f_jaddr;
    fd = $fopen("dv/exu_vectors.txt", "r");
    assert (fd != 0) else begin
      $display("could not open dv/exu_vectors.txt");
      abort_run();
    end
    num_vecs = 0;
    while (!$feof(fd)) begin
      cnt = $fgets(line, fd);
      // skip comments and blank lines
      if (cnt > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
        cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", name, f_cls, f_op,
                      f_word, f_a, f_b, f_pc, f_imm, f_rd, f_res, f_jmp, f_jaddr);
        assert (cnt == 12 && num_vecs < max_vecs) else begin
          $display("vector file line could not be parsed: %0s", line);
          abort_run();
        end
        vec_name[num_vecs]  = name;
        vec_class[num_vecs] = f_cls[1:0];
        vec_op[num_vecs]    = f_op[3:0];
        vec_word[num_vecs]  = f_word[0];
        vec_op1[num_vecs]   = f_a;
        vec_op2[num_vecs]   = f_b;
        vec_pc[num_vecs]    = f_pc;
        vec_imm[num_vecs]   = f_imm;
        vec_rd[num_vecs]    = f_rd[4:0];
        vec_res[num_vecs]   = f_res;
        vec_jump[num_vecs]  = f_jmp[0];
        vec_jaddr[num_vecs] = f_jaddr;
        num_vecs++;
      end
    end
    $fclose(fd);
    assert (num_vecs > 0) else begin
      $display("no operations found in dv/exu_vectors.txt");
      abort_run();
    end
  endtask

  // compare the presented result against the oldest outstanding op
  task automatic check_output();
    int idx;
    assert (pending.size() > 0) else begin
      $display("a result was presented with no operation outstanding");
      abort_run();
    end
    idx = pending.pop_front();
    assert (res_o === vec_res[idx]) else begin
      $display("Mismatch %0s res expected %h actual %h", vec_name[idx], vec_res[idx], res_o);
      abort_run();
    end
    assert (rd_idx_o === vec_rd[idx]) else begin
      $display("Mismatch %0s rd_idx expected %h actual %h", vec_name[idx], vec_rd[idx],
               rd_idx_o);
      abort_run();
    end
    assert (jump_o === vec_jump[idx]) else begin
      $display("Mismatch %0s jump expected %h actual %h", vec_name[idx], vec_jump[idx], jump_o);
      abort_run();
    end
    assert (jump_addr_o === vec_jaddr[idx]) else begin
      $display("Mismatch %0s jump_addr expected %h actual %h", vec_name[idx], vec_jaddr[idx],
               jump_addr_o);
      abort_run();
    end
  endtask

  // called at a falling edge, samples the settled handshakes before the next rise
  task automatic sample_cycle(output logic accepted);
    out_ready_i = ($urandom % 4) != 0;
    #1;
    accepted = in_valid_i & in_ready_o;
    if (out_valid_o && out_ready_i) begin
      check_output();
    end
  endtask

  task automatic send_op(input int idx);
    logic accepted;
    int   waited;
    @(negedge clk);
    class_i    = exu_class_e'(vec_class[idx]);
    op_i       = vec_op[idx];
    word_i     = vec_word[idx];
    op1_i      = vec_op1[idx];
    op2_i      = vec_op2[idx];
    pc_i       = vec_pc[idx];
    imm_i      = vec_imm[idx];
    rd_idx_i   = vec_rd[idx];
    in_valid_i = 1'b1;
    sample_cycle(accepted);
    waited = 0;
    while (!accepted) begin
      waited++;
      assert (waited < wait_limit) else begin
        $display("timed out waiting for in_ready_o on %0s", vec_name[idx]);
        abort_run();
      end
      @(negedge clk);
      sample_cycle(accepted);
    end
    pending.push_back(idx);
  endtask

  task automatic drain_results();
    logic accepted;
    int   waited;
    @(negedge clk);
    in_valid_i = 1'b0;
    sample_cycle(accepted);
    waited = 0;
    while (pending.size() > 0) begin
      waited++;
      assert (waited < wait_limit) else begin
        $display("timed out waiting for out_valid_o, %0d results missing", pending.size());
        abort_run();
      end
      @(negedge clk);
      sample_cycle(accepted);
    end
  endtask

  task automatic wait_ready_after_reset();
    int waited;
    waited = 0;
    @(negedge clk);
    #1;
    while (!in_ready_o) begin
      waited++;
      assert (waited < 20) else begin
        $display("in_ready_o did not rise after reset release");
        abort_run();
      end
      @(negedge clk);
      #1;
    end
  endtask

  initial begin
    void'($urandom(32'h4317_b491));
    arst_n_i    = 1'b0;
    in_valid_i  = 1'b0;
    class_i     = cls_alu;
    op_i        = '0;
    word_i      = 1'b0;
    op1_i       = '0;
    op2_i       = '0;
    pc_i        = '0;
    imm_i       = '0;
    rd_idx_i    = '0;
    out_ready_i = 1'b0;
    read_vectors();
    repeat (reset_cycles) @(negedge clk);
    assert (!out_valid_o && !in_ready_o) else begin
      $display("handshake outputs were active during reset");
      abort_run();
    end
    arst_n_i = 1'b1;
    wait_ready_after_reset();
    for (int i = 0; i < num_vecs; i++) begin
      send_op(i);
    end
    drain_results();
    // nothing may show up twice
    repeat (5) begin
      @(negedge clk);
      out_ready_i = 1'b1;
      #1;
      assert (!out_valid_o) else begin
        $display("out_valid_o raised after all results were taken");
        abort_run();
      end
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* dv/exu_vectors.txt */
// name class op word op1 op2 pc imm rd, then expected res jump jump_addr
// class 0 alu, 1 branch, 2 divide; all numeric fields in hex
add    0 0 0 7fffffffffffffff 1 0 0 01 8000000000000000 0 0
sub    0 1 0 3 5 0 0 02 fffffffffffffffe 0 0
sll    0 2 0 1 3f 0 0 03 8000000000000000 0 0
srl    0 3 0 8000000000000000 4 0 0 04 0800000000000000 0 0
sra    0 4 0 8000000000000000 4 0 0 05 f800000000000000 0 0
slt    0 5 0 ffffffffffffffff 1 0 0 06 1 0 0
sltu   0 6 0 ffffffffffffffff 1 0 0 07 0 0 0
xor    0 7 0 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 0 08 f0f0f0f0f0f0f0f0 0 0
or     0 8 0 f0f0f0f0 0f0f0f0f00000000 0 0 09 0f0f0f0ff0f0f0f0 0 0
and    0 9 0 123456789abcdef0 ffffffff 0 0 0a 9abcdef0 0 0
lui    0 a 0 0 ffffffff80000000 0 0 0b ffffffff80000000 0 0
addw   0 0 1 7fffffff 1 0 0 0c ffffffff80000000 0 0
subw   0 1 1 1234567800000001 2 0 0 0d ffffffffffffffff 0 0
sllw   0 2 1 1 1f 0 0 0e ffffffff80000000 0 0
srlw   0 3 1 ffffffff80000000 4 0 0 0f 8000000 0 0
sraw   0 4 1 80000000 4 0 0 10 fffffffff8000000 0 0
jal    1 0 0 0 0 1000 100 11 1004 1 1100
jalr   1 1 0 2001 0 1000 10 12 1004 1 2010
beq    1 2 0 5 5 1000 fffffffffffffff0 13 0 1 ff0
bne    1 3 0 5 5 1000 8 14 0 0 1008
blt    1 4 0 ffffffffffffffff 1 2000 20 15 0 1 2020
bge    1 5 0 ffffffffffffffff 1 2000 40 16 0 0 2040
bltu   1 6 0 ffffffffffffffff 1 3000 4 17 0 0 3004
bgeu   1 7 0 ffffffffffffffff 1 3000 8 18 0 1 3008
div    2 0 0 fffffffffffffff9 2 0 0 19 fffffffffffffffd 0 0
divu   2 1 0 64 7 0 0 1a e 0 0
rem    2 2 0 fffffffffffffff9 2 0 0 1b ffffffffffffffff 0 0
remu   2 3 0 64 7 0 0 1c 2 0 0
divz   2 0 0 64 0 0 0 1d ffffffffffffffff 0 0
remz   2 2 0 64 0 0 0 1e 64 0 0
divov  2 0 0 8000000000000000 ffffffffffffffff 0 0 1f 8000000000000000 0 0
remov  2 2 0 8000000000000000 ffffffffffffffff 0 0 00 0 0 0
divw   2 0 1 fffffff9 2 0 0 01 fffffffffffffffd 0 0
divuw  2 1 1 ffffffff 2 0 0 02 7fffffff 0 0
remwz  2 2 1 fffffff9 0 0 0 03 fffffffffffffff9 0 0
divwov 2 0 1 80000000 ffffffff 0 0 04 ffffffff80000000 0 0
addend 0 0 0 5 7 0 0 05 c 0 0

/* build.f */
+incdir+src
src/exu_pkg.sv
src/exu_alu.sv
src/exu_div.sv
src/exu_div_cnt.sv
src/exu_ctrl.sv
src/exu_top.sv
dv/exu_checker.sv
dv/exu_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module exu_tb -o exu_sim \
  && ./obj_dir/exu_sim > sim.log 2>&1 \
  || echo "simulation did not complete" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0
